//--- Makefile
# Verilator build and run for the qubit controller pulse path

VERILATOR ?= verilator
TOP       ?= qctl_tb
FILELIST  ?= qctl_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the simulation output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- elem_dispatch.sv
`default_nettype none

module elem_dispatch (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 start,
	input  logic                                 pulse_valid,
	output logic                                 pulse_ready,
	input  qctl_pkg::pulse_cmd_t                 pulse,
	output logic                                 done,
	output logic                                 qdrv_stb,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] qdrv_env_start,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] qdrv_env_length,
	output logic [qctl_pkg::AMP_WIDTH-1:0]       qdrv_amp,
	output logic [qctl_pkg::FREQ_WIDTH-1:0]      qdrv_freq,
	output logic [qctl_pkg::PHASE_WIDTH-1:0]     qdrv_phase,
	output logic [qctl_pkg::MODE_WIDTH-1:0]      qdrv_mode,
	output logic                                 rdrv_stb,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] rdrv_env_start,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] rdrv_env_length,
	output logic [qctl_pkg::AMP_WIDTH-1:0]       rdrv_amp,
	output logic [qctl_pkg::FREQ_WIDTH-1:0]      rdrv_freq,
	output logic [qctl_pkg::PHASE_WIDTH-1:0]     rdrv_phase,
	output logic [qctl_pkg::MODE_WIDTH-1:0]      rdrv_mode,
	output logic                                 rdlo_stb,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] rdlo_env_start,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] rdlo_env_length,
	output logic [qctl_pkg::AMP_WIDTH-1:0]       rdlo_amp,
	output logic [qctl_pkg::FREQ_WIDTH-1:0]      rdlo_freq,
	output logic [qctl_pkg::PHASE_WIDTH-1:0]     rdlo_phase,
	output logic [qctl_pkg::MODE_WIDTH-1:0]      rdlo_mode,
	input  logic                                 qdrv_busy,
	input  logic                                 rdrv_busy,
	input  logic                                 rdlo_busy
);

	logic [3:0] busy_vec;
	logic [3:0] stb_vec;
	logic [2:0] sel;
	logic       blocked;
	logic       pop;
	logic       end_pop;
	logic       end_seen;
	logic       idle;
	logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] short_start;
	logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] short_length;

	// Slot 3 is ELEM_NONE, never busy
	assign busy_vec = {1'b0, rdlo_busy, rdrv_busy, qdrv_busy};
	assign stb_vec  = {1'b0, rdlo_stb, rdrv_stb, qdrv_stb};
	assign blocked  = busy_vec[pulse.elem] | stb_vec[pulse.elem];

	assign pulse_ready = pulse.last | !blocked; // Head of line waits, order stays strict
	assign pop         = pulse_valid && pulse_ready && !pulse.last;
	assign end_pop     = pulse_valid && pulse.last;
	assign sel         = pop ? (3'b001 << pulse.elem) : 3'b000;
	assign idle        = !(|busy_vec) && !(|stb_vec);

	// Qubit drive has the narrow 10-bit envelope fields
	assign short_start  = qctl_pkg::ENV_FIELD_WIDTH'(pulse.env_word[9:0]);
	assign short_length = qctl_pkg::ENV_FIELD_WIDTH'(pulse.env_word[21:12]);

	// ----------------------------------------
	// Strobes and done
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			{rdlo_stb, rdrv_stb, qdrv_stb} <= 3'b000;
		else
			{rdlo_stb, rdrv_stb, qdrv_stb} <= sel;
	end

	always_ff @(posedge clk) begin
		if (rst || start) begin
			done     <= 1'b0;
			end_seen <= 1'b0;
		end else begin
			if (end_pop)
				end_seen <= 1'b1;
			if ((end_pop || end_seen) && idle)
				done <= 1'b1; // Held until the next start
		end
	end

	// ----------------------------------------
	// Element field registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (sel[qctl_pkg::ELEM_QDRV]) begin
			qdrv_env_start  <= short_start;
			qdrv_env_length <= short_length;
			qdrv_amp        <= pulse.amp;
			qdrv_freq       <= pulse.freq;
			qdrv_phase      <= pulse.phase;
			qdrv_mode       <= pulse.mode;
		end
		if (sel[qctl_pkg::ELEM_RDRV]) begin
			rdrv_env_start  <= pulse.env_word[11:0];
			rdrv_env_length <= pulse.env_word[23:12];
			rdrv_amp        <= pulse.amp;
			rdrv_freq       <= pulse.freq;
			rdrv_phase      <= pulse.phase;
			rdrv_mode       <= pulse.mode;
		end
		if (sel[qctl_pkg::ELEM_RDLO]) begin
			rdlo_env_start  <= pulse.env_word[11:0];
			rdlo_env_length <= pulse.env_word[23:12];
			rdlo_amp        <= pulse.amp;
			rdlo_freq       <= pulse.freq;
			rdlo_phase      <= pulse.phase;
			rdlo_mode       <= pulse.mode;
		end
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (rst)
		$onehot0({qdrv_stb, rdrv_stb, rdlo_stb}));

endmodule

`default_nettype wire

//--- instr_fetch.sv
`default_nettype none

module instr_fetch (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  start,
	output logic [qctl_pkg::CMD_ADDR_WIDTH-1:0]   cmd_read_addr,
	output logic                                  cmd_read_en,
	input  qctl_pkg::cmd_word_t                   command,
	input  logic [qctl_pkg::CMD_CNT_WIDTH-1:0]    fifo_count,
	output logic                                  push_valid,
	output qctl_pkg::cmd_word_t                   push_data
);

	logic                                  running;
	logic [qctl_pkg::CMD_ADDR_WIDTH-1:0]   instr_ptr;
	logic [qctl_pkg::CMD_READ_LATENCY-1:0] en_pipe; // One flag per latency stage
	logic [qctl_pkg::CMD_CNT_WIDTH-1:0]    inflight;
	logic [qctl_pkg::CMD_CNT_WIDTH:0]      level;
	logic                                  end_push;

	// ----------------------------------------
	// Credit accounting
	// ----------------------------------------
	always_comb begin
		inflight = '0;
		for (int i = 0; i < qctl_pkg::CMD_READ_LATENCY; i++)
			inflight = inflight + qctl_pkg::CMD_CNT_WIDTH'(en_pipe[i]);
	end

	assign level       = {1'b0, inflight} + {1'b0, fifo_count};
	assign cmd_read_en = running && (level < qctl_pkg::CMD_FIFO_DEPTH);
	assign cmd_read_addr = instr_ptr;

	// Returning data lines up with the oldest flag
	assign push_valid = running && en_pipe[qctl_pkg::CMD_READ_LATENCY-1];
	assign push_data  = command;
	assign end_push   = push_valid &&
		(command[qctl_pkg::OP_HI:qctl_pkg::OP_LO] == qctl_pkg::OP_END);

	// ----------------------------------------
	// Sequencing
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			running   <= 1'b0;
			instr_ptr <= '0;
			en_pipe   <= '0;
		end else if (start) begin
			running   <= 1'b1;
			instr_ptr <= '0;
			en_pipe   <= '0;
		end else if (end_push) begin
			running <= 1'b0; // Reads still in flight are dropped
			en_pipe <= '0;
		end else begin
			en_pipe <= {en_pipe[qctl_pkg::CMD_READ_LATENCY-2:0], cmd_read_en};
			if (cmd_read_en)
				instr_ptr <= instr_ptr + 1'b1;
		end
	end

	// Reads in flight never outrun the space left in the command FIFO
	a_credit: assert property (@(posedge clk) disable iff (rst)
		level <= qctl_pkg::CMD_FIFO_DEPTH);

endmodule

`default_nettype wire

//--- pulse_decoder.sv
`default_nettype none

module pulse_decoder (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   word_valid,
	output logic                   word_ready,
	input  qctl_pkg::cmd_word_t    word,
	output logic                   pulse_valid,
	input  logic                   pulse_ready,
	output qctl_pkg::pulse_cmd_t   pulse
);

	logic [3:0]                      opcode;
	logic [qctl_pkg::CFG_WIDTH-1:0]  cfg;
	logic                            is_end;
	logic                            is_pulse;
	logic                            keep;
	qctl_pkg::pulse_cmd_t            next_pulse;

	assign opcode   = word[qctl_pkg::OP_HI:qctl_pkg::OP_LO];
	assign cfg      = word[qctl_pkg::CFG_HI:qctl_pkg::CFG_LO];
	assign is_end   = (opcode == qctl_pkg::OP_END);
	assign is_pulse = (opcode == qctl_pkg::OP_PULSE) &&
		(cfg[qctl_pkg::SEL_WIDTH-1:0] != qctl_pkg::ELEM_NONE);
	assign keep     = is_end || is_pulse; // Everything else is consumed silently

	// Output stage free or draining this cycle
	assign word_ready = !pulse_valid || pulse_ready;

	always_comb begin
		next_pulse = '0;
		if (is_end) begin
			next_pulse.elem = qctl_pkg::ELEM_NONE;
			next_pulse.last = 1'b1;
		end else begin
			next_pulse.elem     = cfg[qctl_pkg::SEL_WIDTH-1:0];
			next_pulse.mode     = cfg[qctl_pkg::CFG_WIDTH-1:qctl_pkg::SEL_WIDTH];
			next_pulse.env_word = word[qctl_pkg::ENV_HI:qctl_pkg::ENV_LO];
			next_pulse.amp      = word[qctl_pkg::AMP_HI:qctl_pkg::AMP_LO];
			next_pulse.freq     = word[qctl_pkg::FREQ_HI:qctl_pkg::FREQ_LO];
			next_pulse.phase    = word[qctl_pkg::PHASE_HI:qctl_pkg::PHASE_LO];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			pulse_valid <= 1'b0;
		else if (word_ready)
			pulse_valid <= word_valid && keep;
	end

	always_ff @(posedge clk) begin
		if (word_ready && word_valid && keep)
			pulse <= next_pulse;
	end

endmodule

`default_nettype wire

//--- qctl_core.f
qctl_pkg.sv
sync_fifo.sv
instr_fetch.sv
pulse_decoder.sv
elem_dispatch.sv
qctl_core.sv
qctl_tb.sv

//--- qctl_core.sv
`default_nettype none

module qctl_core (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 start,
	output logic [qctl_pkg::CMD_ADDR_WIDTH-1:0]  cmd_read_addr,
	output logic                                 cmd_read_en,
	input  qctl_pkg::cmd_word_t                  command,
	output logic                                 done,
	output logic                                 qdrv_stb,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] qdrv_env_start,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] qdrv_env_length,
	output logic [qctl_pkg::AMP_WIDTH-1:0]       qdrv_amp,
	output logic [qctl_pkg::FREQ_WIDTH-1:0]      qdrv_freq,
	output logic [qctl_pkg::PHASE_WIDTH-1:0]     qdrv_phase,
	output logic [qctl_pkg::MODE_WIDTH-1:0]      qdrv_mode,
	output logic                                 rdrv_stb,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] rdrv_env_start,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] rdrv_env_length,
	output logic [qctl_pkg::AMP_WIDTH-1:0]       rdrv_amp,
	output logic [qctl_pkg::FREQ_WIDTH-1:0]      rdrv_freq,
	output logic [qctl_pkg::PHASE_WIDTH-1:0]     rdrv_phase,
	output logic [qctl_pkg::MODE_WIDTH-1:0]      rdrv_mode,
	output logic                                 rdlo_stb,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] rdlo_env_start,
	output logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] rdlo_env_length,
	output logic [qctl_pkg::AMP_WIDTH-1:0]       rdlo_amp,
	output logic [qctl_pkg::FREQ_WIDTH-1:0]      rdlo_freq,
	output logic [qctl_pkg::PHASE_WIDTH-1:0]     rdlo_phase,
	output logic [qctl_pkg::MODE_WIDTH-1:0]      rdlo_mode,
	input  logic                                 qdrv_busy,
	input  logic                                 rdrv_busy,
	input  logic                                 rdlo_busy
);

	wire                                    cmd_push_valid;
	wire qctl_pkg::cmd_word_t               cmd_push_data;
	wire [qctl_pkg::CMD_CNT_WIDTH-1:0]      cmd_count;
	wire                                    word_valid;
	wire                                    word_ready;
	wire qctl_pkg::cmd_word_t               word;
	wire                                    dec_valid;
	wire                                    dec_ready;
	wire qctl_pkg::pulse_cmd_t              dec_pulse;
	wire                                    pulse_valid;
	wire                                    pulse_ready;
	wire qctl_pkg::pulse_cmd_t              pulse;

	instr_fetch u_fetch (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.cmd_read_addr (cmd_read_addr),
		.cmd_read_en   (cmd_read_en),
		.command       (command),
		.fifo_count    (cmd_count),
		.push_valid    (cmd_push_valid),
		.push_data     (cmd_push_data)
	);

	// Fetch throttles on count, so in_ready is not needed upstream
	sync_fifo #(
		.T     (qctl_pkg::cmd_word_t),
		.DEPTH (qctl_pkg::CMD_FIFO_DEPTH)
	) u_cmd_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (cmd_push_valid),
		.in_ready  (),
		.in_data   (cmd_push_data),
		.out_valid (word_valid),
		.out_ready (word_ready),
		.out_data  (word),
		.count     (cmd_count)
	);

	pulse_decoder u_decoder (
		.clk         (clk),
		.rst         (rst),
		.word_valid  (word_valid),
		.word_ready  (word_ready),
		.word        (word),
		.pulse_valid (dec_valid),
		.pulse_ready (dec_ready),
		.pulse       (dec_pulse)
	);

	sync_fifo #(
		.T     (qctl_pkg::pulse_cmd_t),
		.DEPTH (qctl_pkg::PULSE_FIFO_DEPTH)
	) u_pulse_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (dec_valid),
		.in_ready  (dec_ready),
		.in_data   (dec_pulse),
		.out_valid (pulse_valid),
		.out_ready (pulse_ready),
		.out_data  (pulse),
		.count     ()
	);

	elem_dispatch u_dispatch (
		.clk             (clk),
		.rst             (rst),
		.start           (start),
		.pulse_valid     (pulse_valid),
		.pulse_ready     (pulse_ready),
		.pulse           (pulse),
		.done            (done),
		.qdrv_stb        (qdrv_stb),
		.qdrv_env_start  (qdrv_env_start),
		.qdrv_env_length (qdrv_env_length),
		.qdrv_amp        (qdrv_amp),
		.qdrv_freq       (qdrv_freq),
		.qdrv_phase      (qdrv_phase),
		.qdrv_mode       (qdrv_mode),
		.rdrv_stb        (rdrv_stb),
		.rdrv_env_start  (rdrv_env_start),
		.rdrv_env_length (rdrv_env_length),
		.rdrv_amp        (rdrv_amp),
		.rdrv_freq       (rdrv_freq),
		.rdrv_phase      (rdrv_phase),
		.rdrv_mode       (rdrv_mode),
		.rdlo_stb        (rdlo_stb),
		.rdlo_env_start  (rdlo_env_start),
		.rdlo_env_length (rdlo_env_length),
		.rdlo_amp        (rdlo_amp),
		.rdlo_freq       (rdlo_freq),
		.rdlo_phase      (rdlo_phase),
		.rdlo_mode       (rdlo_mode),
		.qdrv_busy       (qdrv_busy),
		.rdrv_busy       (rdrv_busy),
		.rdlo_busy       (rdlo_busy)
	);

endmodule

`default_nettype wire

//--- qctl_pkg.sv
`default_nettype none

package qctl_pkg;

	// ----------------------------------------
	// Widths and memory timing
	// ----------------------------------------
	localparam int CMD_WIDTH        = 128;
	localparam int CMD_ADDR_WIDTH   = 16;
	localparam int CMD_READ_LATENCY = 2;

	localparam int ENV_WIDTH       = 24;
	localparam int AMP_WIDTH       = 16;
	localparam int FREQ_WIDTH      = 9;
	localparam int PHASE_WIDTH     = 17;
	localparam int CFG_WIDTH       = 4;
	localparam int ENV_FIELD_WIDTH = 12; // Element envelope start and length
	localparam int SEL_WIDTH       = 2;
	localparam int MODE_WIDTH      = CFG_WIDTH - SEL_WIDTH;

	localparam int CMD_FIFO_DEPTH   = 4;
	localparam int PULSE_FIFO_DEPTH = 4;
	localparam int CMD_CNT_WIDTH    = $clog2(CMD_FIFO_DEPTH + 1);

	// ----------------------------------------
	// Opcodes and field positions
	// ----------------------------------------
	localparam logic [3:0] OP_END   = 4'd0;
	localparam logic [3:0] OP_PULSE = 4'd1;
	localparam logic [3:0] OP_NOP   = 4'd2; // Unknown opcodes behave the same

	localparam int OP_HI    = 127;
	localparam int OP_LO    = 124;
	localparam int CFG_HI   = 123;
	localparam int CFG_LO   = 120;
	localparam int ENV_HI   = 119;
	localparam int ENV_LO   = 96;
	localparam int AMP_HI   = 95;
	localparam int AMP_LO   = 80;
	localparam int FREQ_HI  = 72;
	localparam int FREQ_LO  = 64;
	localparam int PHASE_HI = 48;
	localparam int PHASE_LO = 32;

	// Element select, cfg bits 1:0
	localparam logic [SEL_WIDTH-1:0] ELEM_QDRV = 2'd0;
	localparam logic [SEL_WIDTH-1:0] ELEM_RDRV = 2'd1;
	localparam logic [SEL_WIDTH-1:0] ELEM_RDLO = 2'd2;
	localparam logic [SEL_WIDTH-1:0] ELEM_NONE = 2'd3;

	typedef logic [CMD_WIDTH-1:0] cmd_word_t;

	typedef struct packed {
		logic [SEL_WIDTH-1:0]   elem;
		logic [MODE_WIDTH-1:0]  mode;
		logic [ENV_WIDTH-1:0]   env_word;
		logic [AMP_WIDTH-1:0]   amp;
		logic [FREQ_WIDTH-1:0]  freq;
		logic [PHASE_WIDTH-1:0] phase;
		logic                   last; // End of program marker
	} pulse_cmd_t;

endpackage

`default_nettype wire

//--- qctl_tb.sv
`default_nettype none

module qctl_tb;

	localparam int PROG_LEN        = 24; // Body words ahead of the end word
	localparam int NUM_PROGS       = 2;
	localparam int MAX_BUSY        = 6;
	localparam int MEM_AW          = 6;
	localparam int MEM_DEPTH       = 1 << MEM_AW;
	localparam int WATCHDOG_CYCLES = NUM_PROGS * (PROG_LEN + 1) * (MAX_BUSY + 8);
	localparam int LAT             = qctl_pkg::CMD_READ_LATENCY;

	// Unread cycles return a live qdrv pulse
	localparam qctl_pkg::cmd_word_t UNREAD_WORD = {qctl_pkg::OP_PULSE, 124'h0};

	typedef struct packed {
		logic [qctl_pkg::MODE_WIDTH-1:0]      mode;
		logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] env_start;
		logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] env_length;
		logic [qctl_pkg::AMP_WIDTH-1:0]       amp;
		logic [qctl_pkg::FREQ_WIDTH-1:0]      freq;
		logic [qctl_pkg::PHASE_WIDTH-1:0]     phase;
	} strobe_t;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic [qctl_pkg::CMD_ADDR_WIDTH-1:0]  cmd_read_addr;
	logic                                 cmd_read_en;
	qctl_pkg::cmd_word_t                  command = '0;
	logic                                 done;
	logic                                 qdrv_stb, rdrv_stb, rdlo_stb;
	logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] qdrv_env_start, rdrv_env_start, rdlo_env_start;
	logic [qctl_pkg::ENV_FIELD_WIDTH-1:0] qdrv_env_length, rdrv_env_length, rdlo_env_length;
	logic [qctl_pkg::AMP_WIDTH-1:0]       qdrv_amp, rdrv_amp, rdlo_amp;
	logic [qctl_pkg::FREQ_WIDTH-1:0]      qdrv_freq, rdrv_freq, rdlo_freq;
	logic [qctl_pkg::PHASE_WIDTH-1:0]     qdrv_phase, rdrv_phase, rdlo_phase;
	logic [qctl_pkg::MODE_WIDTH-1:0]      qdrv_mode, rdrv_mode, rdlo_mode;
	logic [2:0]                           busy_v = '0; // rdlo, rdrv, qdrv
	logic                                 qdrv_busy, rdrv_busy, rdlo_busy;

	qctl_pkg::cmd_word_t                  mem [MEM_DEPTH];
	logic [qctl_pkg::CMD_ADDR_WIDTH-1:0]  addr_pipe [LAT];
	logic [LAT-1:0]                       ren_pipe = '0;
	strobe_t                              exp_q [3][$];
	int                                   busy_left [3];
	int                                   outstanding = 0;
	int                                   mismatches = 0;
	int                                   rule_errors = 0;
	string                                elem_name [3] = '{"qdrv", "rdrv", "rdlo"};

	assign qdrv_busy = busy_v[0];
	assign rdrv_busy = busy_v[1];
	assign rdlo_busy = busy_v[2];

	qctl_core i_qctl_core (.*);

	initial begin
		forever #20 clk = ~clk;
	end

	// ----------------------------------------
	// Memory and element models
	// ----------------------------------------
	always @(posedge clk) begin
		logic [qctl_pkg::CMD_ADDR_WIDTH-1:0] addr_now;
		logic                                en_now;
		addr_now = cmd_read_addr;
		en_now   = cmd_read_en;
		#1;
		for (int i = LAT - 1; i > 0; i--)
			addr_pipe[i] = addr_pipe[i-1];
		addr_pipe[0] = addr_now;
		ren_pipe = {ren_pipe[LAT-2:0], en_now};
		if (ren_pipe[LAT-1])
			command = mem[addr_pipe[LAT-1][MEM_AW-1:0]];
		else
			command = UNREAD_WORD;
	end

	always @(posedge clk) begin
		logic [2:0] stb_now;
		logic       rst_now;
		stb_now = {rdlo_stb, rdrv_stb, qdrv_stb};
		rst_now = rst;
		#1;
		for (int e = 0; e < 3; e++) begin
			if (rst_now)
				busy_left[e] = 0;
			else if (stb_now[e])
				busy_left[e] = $urandom_range(MAX_BUSY, 0); // Burst starts the cycle after
			else if (busy_left[e] > 0)
				busy_left[e]--;
			busy_v[e] = (busy_left[e] > 0);
		end
	end

	task automatic rule_error(input string msg);
		rule_errors++;
		$display("ERROR %s", msg);
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] want);
		a_field: assert (got == want)
		else begin
			mismatches++;
			$display("MISMATCH %s got %0h expected %0h", name, got, want);
		end
	endtask

	// Envelope mapping differs between the qubit drive and the readout elements
	function automatic strobe_t expected_strobe(input qctl_pkg::cmd_word_t w);
		logic [qctl_pkg::ENV_WIDTH-1:0] env;
		logic [qctl_pkg::CFG_WIDTH-1:0] cfg;
		strobe_t                        s;
		env = w[qctl_pkg::ENV_HI:qctl_pkg::ENV_LO];
		cfg = w[qctl_pkg::CFG_HI:qctl_pkg::CFG_LO];
		s.mode = cfg[3:2];
		if (cfg[1:0] == qctl_pkg::ELEM_QDRV) begin
			s.env_start  = {2'b00, env[9:0]};
			s.env_length = {2'b00, env[21:12]};
		end else begin
			s.env_start  = env[11:0];
			s.env_length = env[23:12];
		end
		s.amp   = w[qctl_pkg::AMP_HI:qctl_pkg::AMP_LO];
		s.freq  = w[qctl_pkg::FREQ_HI:qctl_pkg::FREQ_LO];
		s.phase = w[qctl_pkg::PHASE_HI:qctl_pkg::PHASE_LO];
		return s;
	endfunction

	function automatic strobe_t strobe_fields(input int e);
		strobe_t s;
		case (e)
			0:
				s = {qdrv_mode, qdrv_env_start, qdrv_env_length,
					qdrv_amp, qdrv_freq, qdrv_phase};
			1:
				s = {rdrv_mode, rdrv_env_start, rdrv_env_length,
					rdrv_amp, rdrv_freq, rdrv_phase};
			default:
				s = {rdlo_mode, rdlo_env_start, rdlo_env_length,
					rdlo_amp, rdlo_freq, rdlo_phase};
		endcase
		return s;
	endfunction

	task automatic compare_strobe(input int e, input strobe_t got, input strobe_t want);
		check_field({elem_name[e], "_mode"}, 32'(got.mode), 32'(want.mode));
		check_field({elem_name[e], "_env_start"}, 32'(got.env_start), 32'(want.env_start));
		check_field({elem_name[e], "_env_length"}, 32'(got.env_length), 32'(want.env_length));
		check_field({elem_name[e], "_amp"}, 32'(got.amp), 32'(want.amp));
		check_field({elem_name[e], "_freq"}, 32'(got.freq), 32'(want.freq));
		check_field({elem_name[e], "_phase"}, 32'(got.phase), 32'(want.phase));
	endtask

	// Random program at address 0, fill words behind it are live qdrv pulses
	task automatic load_program();
		qctl_pkg::cmd_word_t w;
		int                  kind;
		logic [15:0]         a16;
		for (int a = 0; a < MEM_DEPTH; a++) begin
			a16 = 16'(a);
			mem[a] = {qctl_pkg::OP_PULSE, 4'h0, {7{a16}}, a16[7:0]};
		end
		for (int a = 0; a < PROG_LEN; a++) begin
			w = {$urandom, $urandom, $urandom, $urandom};
			kind = $urandom_range(9, 0);
			if (kind < 6) begin
				w[qctl_pkg::OP_HI:qctl_pkg::OP_LO] = qctl_pkg::OP_PULSE;
				if (w[qctl_pkg::CFG_LO+1:qctl_pkg::CFG_LO] != qctl_pkg::ELEM_NONE) begin
					exp_q[w[qctl_pkg::CFG_LO+1:qctl_pkg::CFG_LO]].push_back(expected_strobe(w));
					outstanding++;
				end
			end else if (kind < 8) begin
				w[qctl_pkg::OP_HI:qctl_pkg::OP_LO] = qctl_pkg::OP_NOP;
			end else begin
				w[qctl_pkg::OP_HI:qctl_pkg::OP_LO] = 4'($urandom_range(15, 3)); // Unknown opcode
			end
			mem[a] = w;
		end
		mem[PROG_LEN] = {qctl_pkg::OP_END, 124'({$urandom, $urandom, $urandom, $urandom})};
	endtask

	// ----------------------------------------
	// Scoreboard
	// ----------------------------------------
	always @(posedge clk) begin
		logic [2:0] stb_now;
		strobe_t    want;
		stb_now = {rdlo_stb, rdrv_stb, qdrv_stb};
		for (int e = 0; e < 3; e++) begin
			if (!rst && stb_now[e]) begin
				if (exp_q[e].size() == 0) begin
					rule_error($sformatf("%s strobed with no command left for it", elem_name[e]));
				end else begin
					want = exp_q[e].pop_front();
					outstanding--;
					compare_strobe(e, strobe_fields(e), want);
				end
			end
		end
	end

	a_qdrv_gap: assert property (@(posedge clk) disable iff (rst)
		qdrv_stb |-> !$past(qdrv_busy) && !$past(qdrv_stb))
		else rule_error("qdrv strobed while busy or right after its previous strobe");
	a_rdrv_gap: assert property (@(posedge clk) disable iff (rst)
		rdrv_stb |-> !$past(rdrv_busy) && !$past(rdrv_stb))
		else rule_error("rdrv strobed while busy or right after its previous strobe");
	a_rdlo_gap: assert property (@(posedge clk) disable iff (rst)
		rdlo_stb |-> !$past(rdlo_busy) && !$past(rdlo_stb))
		else rule_error("rdlo strobed while busy or right after its previous strobe");

	a_done_clean: assert property (@(posedge clk) disable iff (rst)
		(done && !start) |-> (outstanding == 0 && busy_v == 3'b000))
		else rule_error("done high with commands outstanding or an element busy");
	a_done_hold: assert property (@(posedge clk) disable iff (rst)
		$fell(done) |-> $past(start))
		else rule_error("done dropped without a start");
	a_no_read_after_end: assert property (@(posedge clk) disable iff (rst)
		done |-> !cmd_read_en)
		else rule_error("command memory read while done is high");

	initial begin
		void'($urandom(32'hce52_7a2d));
		rst = 1'b1;
		start = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			@(posedge clk);
			#1;
			load_program();
			start = 1'b1;
			@(posedge clk);
			#1 start = 1'b0;
			while (!done)
				@(posedge clk);
			repeat (12) @(posedge clk); // Late reads past the end word would strobe here
			a_drained: assert (outstanding == 0 && done)
			else rule_error($sformatf("program %0d ended with %0d commands undelivered",
				p, outstanding));
		end
		$display("Errors: %0d mismatches, %0d rule violations", mismatches, rule_errors);
		if (mismatches + rule_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles without finishing the programs", WATCHDOG_CYCLES);
		$display("Errors: %0d mismatches, %0d rule violations", mismatches, rule_errors);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- sync_fifo.sv
`default_nettype none

module sync_fifo #(
	parameter type T   = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         in_valid,
	output logic                         in_ready,
	input  T                             in_data,
	output logic                         out_valid,
	input  logic                         out_ready,
	output T                             out_data,
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic push;
	logic pop;

	assign in_ready  = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// A write offered while full waits unchanged until it is taken
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		(in_valid && !in_ready) |=> (in_valid && $stable(in_data)));

	// Occupancy agrees with the pointer distance
	a_count_max: assert property (@(posedge clk) disable iff (rst)
		count <= CNT_W'(DEPTH) &&
		(int'(count) % DEPTH) == ((int'(wr_ptr) + DEPTH - int'(rd_ptr)) % DEPTH));

endmodule

`default_nettype wire
